// File: source/conv_pkg.sv
package conv_pkg;

    //////////////////////////////
    // Sizes
    localparam int DATA_W  = 8;
    localparam int NUM_CH  = 3;
    localparam int NUM_KN  = 4;
    localparam int NUM_POS = 3;
    // 16-bit products plus growth of 9 terms
    localparam int PSUM_W  = 20;
    localparam int LINE_W  = 8;
    localparam int POS_W   = $clog2(NUM_POS + 1);

    //////////////////////////////
    // Vector types
    typedef logic signed [DATA_W-1:0]               sample_t;
    typedef logic [NUM_CH*DATA_W-1:0]               pixel_t;
    // Kernel k, channel c in byte k*NUM_CH+c
    typedef logic [NUM_KN*NUM_CH*DATA_W-1:0]        weight_word_t;
    typedef logic signed [PSUM_W-1:0]               psum_t;
    typedef logic [LINE_W-1:0]                      line_len_t;

    // Position 0 holds the oldest pixel
    typedef struct packed {
        logic                   vld;
        logic                   last;
        pixel_t [NUM_POS-1:0]   pix;
    } window_t;

    typedef struct packed {
        logic                   vld;
        logic                   last;
        psum_t [NUM_KN-1:0]     psum;
    } pos_psum_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        RUN,
        DONE
    } ctrl_state_e;

endpackage

// File: source/line_window.sv
`timescale 1ns/1ps

module line_window (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_run,
    input  conv_pkg::line_len_t i_line_len,
    input  conv_pkg::pixel_t    i_data,
    input  logic                i_data_vld,
    output conv_pkg::window_t   o_window
);
    import conv_pkg::*;

    pixel_t [NUM_POS-1:0]   pix_q;
    line_len_t              col_q;
    logic                   col_last;
    logic                   vld_q;
    logic                   last_q;

    assign col_last = (col_q == i_line_len - 1'b1);

    // Newest pixel enters at the top position
    always_ff @(posedge clk) begin
        if (i_data_vld) begin
            pix_q <= {i_data, pix_q[NUM_POS-1:1]};
        end
    end

    // Column within the current line
    always_ff @(posedge clk) begin
        if (rst || !i_run) begin
            col_q <= '0;
        end else if (i_data_vld) begin
            col_q <= col_last ? '0 : col_q + 1'b1;
        end
    end

    // Window complete once NUM_POS pixels of the line are in
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q  <= 1'b0;
            last_q <= 1'b0;
        end else begin
            vld_q  <= i_data_vld && (col_q >= line_len_t'(NUM_POS - 1));
            last_q <= i_data_vld && col_last;
        end
    end

    assign o_window = '{vld: vld_q, last: last_q, pix: pix_q};

    a_data_in_run: assert property (@(posedge clk) disable iff (rst) i_data_vld |-> i_run)
        else $error("pixel strobe outside a run");

endmodule

// File: source/weight_store.sv
`timescale 1ns/1ps

module weight_store (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            i_load_start,
    input  conv_pkg::weight_word_t                          i_weight,
    input  logic                                            i_weight_vld,
    output conv_pkg::weight_word_t [conv_pkg::NUM_POS-1:0]  o_weights,
    output logic                                            o_weights_ready
);
    import conv_pkg::*;

    logic [POS_W-1:0]   load_cnt;
    logic               full;
    logic               take;

    assign full = (load_cnt == POS_W'(NUM_POS));
    assign take = i_weight_vld && !full;

    always_ff @(posedge clk) begin
        if (rst || i_load_start) begin
            load_cnt <= '0;
        end else if (take) begin
            load_cnt <= load_cnt + 1'b1;
        end
    end

    // n-th accepted word goes to position n
    always_ff @(posedge clk) begin
        if (take) begin
            o_weights[load_cnt] <= i_weight;
        end
    end

    // High already in the cycle of the last word
    assign o_weights_ready = full || (take && (load_cnt == POS_W'(NUM_POS - 1)));

    a_no_overfill: assert property (@(posedge clk) disable iff (rst) i_weight_vld |-> !full)
        else $error("weight word sent to a full store");

endmodule

// File: source/engine_ctrl.sv
`timescale 1ns/1ps

module engine_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_start,
    input  conv_pkg::line_len_t i_num_lines,
    input  logic                i_weights_ready,
    input  logic                i_psum_end,
    output logic                o_load_start,
    output logic                o_weight_req,
    output logic                o_data_req,
    output logic                o_done
);
    import conv_pkg::*;

    ctrl_state_e    state;
    ctrl_state_e    state_nxt;
    line_len_t      line_cnt;
    logic           last_line;

    assign o_load_start = i_start && (state == IDLE || state == DONE);
    assign last_line    = (line_cnt == i_num_lines - 1'b1);

    //////////////////////////////
    // State machine
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE, DONE: begin
                if (i_start) begin
                    state_nxt = LOAD;
                end
            end
            LOAD: begin
                if (i_weights_ready) begin
                    state_nxt = RUN;
                end
            end
            RUN: begin
                if (i_psum_end && last_line) begin
                    state_nxt = DONE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Finished lines of this run
    always_ff @(posedge clk) begin
        if (rst || o_load_start) begin
            line_cnt <= '0;
        end else if (state == RUN && i_psum_end) begin
            line_cnt <= line_cnt + 1'b1;
        end
    end

    assign o_weight_req = (state == LOAD);
    assign o_data_req   = (state == RUN);
    assign o_done       = (state == DONE);

    a_req_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(o_weight_req && o_data_req))
        else $error("weight and data requests overlap");

endmodule

// File: source/kc_pe.sv
`timescale 1ns/1ps

module kc_pe (
    input  logic                    clk,
    input  logic                    rst,
    input  conv_pkg::pixel_t        i_pixel,
    input  conv_pkg::weight_word_t  i_weights,
    input  logic                    i_vld,
    input  logic                    i_last,
    output conv_pkg::pos_psum_t     o_psum
);
    import conv_pkg::*;

    logic signed [2*DATA_W-1:0] prod_q [NUM_KN][NUM_CH];
    psum_t                      ch_sum [NUM_KN];
    psum_t [NUM_KN-1:0]         sum_q;
    logic [1:0]                 vld_q;
    logic [1:0]                 last_q;

    // Stage 1: signed products per kernel and channel
    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_KN; k++) begin
            for (int c = 0; c < NUM_CH; c++) begin
                prod_q[k][c] <= sample_t'(i_pixel[c*DATA_W +: DATA_W])
                              * sample_t'(i_weights[(k*NUM_CH + c)*DATA_W +: DATA_W]);
            end
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_KN; k++) begin
            ch_sum[k] = '0;
            for (int c = 0; c < NUM_CH; c++) begin
                ch_sum[k] = ch_sum[k] + prod_q[k][c];
            end
        end
    end

    // Stage 2: channel sums
    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_KN; k++) begin
            sum_q[k] <= ch_sum[k];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q  <= '0;
            last_q <= '0;
        end else begin
            vld_q  <= {vld_q[0], i_vld};
            last_q <= {last_q[0], i_last};
        end
    end

    assign o_psum = '{vld: vld_q[1], last: last_q[1], psum: sum_q};

endmodule

// File: source/psum_collect.sv
`timescale 1ns/1ps

module psum_collect (
    input  logic                                        clk,
    input  logic                                        rst,
    input  conv_pkg::pos_psum_t [conv_pkg::NUM_POS-1:0] i_pos_psum,
    output conv_pkg::psum_t [conv_pkg::NUM_KN-1:0]      o_psum,
    output logic                                        o_psum_vld,
    output logic                                        o_psum_end
);
    import conv_pkg::*;

    psum_t [NUM_KN-1:0] kn_sum;

    // Per kernel, add the position results
    always_comb begin
        for (int k = 0; k < NUM_KN; k++) begin
            kn_sum[k] = '0;
            for (int p = 0; p < NUM_POS; p++) begin
                kn_sum[k] = kn_sum[k] + i_pos_psum[p].psum[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        o_psum <= kn_sum;
    end

    // Flags follow position 0
    always_ff @(posedge clk) begin
        if (rst) begin
            o_psum_vld <= 1'b0;
            o_psum_end <= 1'b0;
        end else begin
            o_psum_vld <= i_pos_psum[0].vld;
            o_psum_end <= i_pos_psum[0].vld && i_pos_psum[0].last;
        end
    end

    //////////////////////////////
    // All PEs run in lock step
    for (genvar p = 1; p < NUM_POS; p++) begin : g_agree
        a_pos_agree: assert property (@(posedge clk) disable iff (rst)
            (i_pos_psum[p].vld == i_pos_psum[0].vld)
            && (i_pos_psum[p].last == i_pos_psum[0].last))
            else $error("position %0d out of step with position 0", p);
    end

endmodule

// File: source/line_conv_engine.sv
`timescale 1ns/1ps

module line_conv_engine (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    i_start,
    input  conv_pkg::line_len_t                     i_line_len,
    input  conv_pkg::line_len_t                     i_num_lines,
    input  conv_pkg::weight_word_t                  i_weight,
    input  logic                                    i_weight_vld,
    input  conv_pkg::pixel_t                        i_data,
    input  logic                                    i_data_vld,
    output logic                                    o_weight_req,
    output logic                                    o_data_req,
    output conv_pkg::psum_t [conv_pkg::NUM_KN-1:0]  o_psum,
    output logic                                    o_psum_vld,
    output logic                                    o_psum_end,
    output logic                                    o_done
);
    import conv_pkg::*;

    logic                       load_start;
    logic                       weights_ready;
    weight_word_t [NUM_POS-1:0] weights;
    window_t                    window;
    pos_psum_t [NUM_POS-1:0]    pos_psum;

    engine_ctrl u_ctrl (
        .clk                (clk),
        .rst                (rst),
        .i_start            (i_start),
        .i_num_lines        (i_num_lines),
        .i_weights_ready    (weights_ready),
        .i_psum_end         (o_psum_end),
        .o_load_start       (load_start),
        .o_weight_req       (o_weight_req),
        .o_data_req         (o_data_req),
        .o_done             (o_done)
    );

    weight_store u_weights (
        .clk                (clk),
        .rst                (rst),
        .i_load_start       (load_start),
        .i_weight           (i_weight),
        .i_weight_vld       (i_weight_vld),
        .o_weights          (weights),
        .o_weights_ready    (weights_ready)
    );

    line_window u_window (
        .clk                (clk),
        .rst                (rst),
        .i_run              (o_data_req),
        .i_line_len         (i_line_len),
        .i_data             (i_data),
        .i_data_vld         (i_data_vld),
        .o_window           (window)
    );

    // One PE per window position
    for (genvar p = 0; p < NUM_POS; p++) begin : g_pe
        kc_pe u_pe (
            .clk            (clk),
            .rst            (rst),
            .i_pixel        (window.pix[p]),
            .i_weights      (weights[p]),
            .i_vld          (window.vld),
            .i_last         (window.last),
            .o_psum         (pos_psum[p])
        );
    end

    psum_collect u_collect (
        .clk                (clk),
        .rst                (rst),
        .i_pos_psum         (pos_psum),
        .o_psum             (o_psum),
        .o_psum_vld         (o_psum_vld),
        .o_psum_end         (o_psum_end)
    );

endmodule

// File: bench/conv_model.svh
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

typedef psum_t [NUM_KN-1:0] psum_vec_t;

// Expected results, oldest window first
psum_vec_t exp_q[$];

// Dot product of one pixel with one kernel's channel weights
function automatic int position_dot(pixel_t px, weight_word_t w, int k);
    byte a;
    byte b;
    int  acc;
    acc = 0;
    for (int c = 0; c < NUM_CH; c++) begin
        a = px[c*DATA_W +: DATA_W];
        b = w[(k*NUM_CH + c)*DATA_W +: DATA_W];
        acc += int'(a) * int'(b);
    end
    return acc;
endfunction

// Full window sum per kernel, position 0 is the oldest pixel
function automatic psum_vec_t window_psums(pixel_t pix [NUM_POS], weight_word_t w [NUM_POS]);
    psum_vec_t r;
    int        acc;
    for (int k = 0; k < NUM_KN; k++) begin
        acc = 0;
        for (int p = 0; p < NUM_POS; p++) begin
            acc += position_dot(pix[p], w[p], k);
        end
        r[k] = psum_t'(acc);
    end
    return r;
endfunction

`endif

// File: bench/line_conv_engine_tb.sv
`timescale 1ns/1ps

module line_conv_engine_tb;
    import conv_pkg::*;

    `include "conv_model.svh"

    localparam int LEN_A     = 8;
    localparam int LINES_A   = 3;
    localparam int LEN_B     = 5;
    localparam int LINES_B   = 4;
    localparam int TOTAL_PIX = LEN_A*LINES_A + LEN_B*LINES_B;

    logic           clk;
    logic           rst;
    logic           i_start;
    line_len_t      i_line_len;
    line_len_t      i_num_lines;
    weight_word_t   i_weight;
    logic           i_weight_vld;
    pixel_t         i_data;
    logic           i_data_vld;
    logic           o_weight_req;
    logic           o_data_req;
    psum_vec_t      o_psum;
    logic           o_psum_vld;
    logic           o_psum_end;
    logic           o_done;

    integer         seed;
    logic           started;
    logic           win_done;
    logic           line_end;
    weight_word_t   wts [NUM_POS];
    pixel_t         hist [NUM_POS];
    int             cur_len;
    int             lines_seen;
    int             line_results;
    psum_vec_t      want;

    line_conv_engine uut (
        .clk            (clk),
        .rst            (rst),
        .i_start        (i_start),
        .i_line_len     (i_line_len),
        .i_num_lines    (i_num_lines),
        .i_weight       (i_weight),
        .i_weight_vld   (i_weight_vld),
        .i_data         (i_data),
        .i_data_vld     (i_data_vld),
        .o_weight_req   (o_weight_req),
        .o_data_req     (o_data_req),
        .o_psum         (o_psum),
        .o_psum_vld     (o_psum_vld),
        .o_psum_end     (o_psum_end),
        .o_done         (o_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with(input string why);
        $display("*** FAILED ***");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("*** FAILED ***");
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    //////////////////////////////
    // Protocol and timing checks
    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        !started |-> !(o_weight_req || o_data_req || o_psum_vld || o_psum_end || o_done))
        else stop_with("outputs active before the first start pulse");

    a_req_excl: assert property (@(posedge clk) disable iff (rst)
        !(o_weight_req && o_data_req))
        else stop_with("weight and data requests high together");

    a_vld_latency: assert property (@(posedge clk) disable iff (rst)
        o_psum_vld == $past(win_done, 4))
        else stop_with("o_psum_vld not 4 cycles after the completing pixel");

    a_end_latency: assert property (@(posedge clk) disable iff (rst)
        o_psum_end == $past(win_done && line_end, 4))
        else stop_with("o_psum_end not aligned with the last window of a line");

    a_done_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(o_done) |-> ($past(o_psum_end) && !o_data_req))
        else stop_with("o_done rose without a line end or with data request still high");

    // Scoreboard
    always @(negedge clk) begin
        if (!rst && o_psum_vld) begin
            if (exp_q.size() == 0) begin
                stop_with("result arrived with no window pending");
            end else begin
                want = exp_q.pop_front();
                for (int k = 0; k < NUM_KN; k++) begin
                    check_value($sformatf("o_psum[%0d]", k), 32'(o_psum[k]), 32'(want[k]));
                end
                line_results++;
                if (o_psum_end) begin
                    check_value("results per line", line_results, cur_len - 2);
                    line_results = 0;
                    lines_seen++;
                end
            end
        end
    end

    task automatic load_weights();
        do begin
            @(negedge clk);
        end while (!o_weight_req);
        for (int n = 0; n < NUM_POS; n++) begin
            wts[n] = {$random(seed), $random(seed), $random(seed)};
            @(posedge clk);
            i_weight     <= wts[n];
            i_weight_vld <= 1'b1;
            @(negedge clk);
            check_value("o_weight_req", 32'(o_weight_req), 32'd1);
        end
        @(posedge clk);
        i_weight_vld <= 1'b0;
        @(negedge clk);
        check_value("o_weight_req", 32'(o_weight_req), 32'd0);
        check_value("o_data_req", 32'(o_data_req), 32'd1);
    endtask

    task automatic send_pixel(input int col, input int len);
        pixel_t px;
        px = pixel_t'($random(seed));
        // Occasional idle cycle between pixels
        if (($random(seed) & 3) == 0) begin
            @(posedge clk);
            i_data_vld <= 1'b0;
            win_done   <= 1'b0;
            line_end   <= 1'b0;
        end
        @(posedge clk);
        i_data     <= px;
        i_data_vld <= 1'b1;
        win_done   <= (col >= NUM_POS - 1);
        line_end   <= (col == len - 1);
        for (int p = 0; p < NUM_POS - 1; p++) begin
            hist[p] = hist[p+1];
        end
        hist[NUM_POS-1] = px;
        if (col >= NUM_POS - 1) begin
            exp_q.push_back(window_psums(hist, wts));
        end
    endtask

    task automatic run_case(input int len, input int lines);
        @(posedge clk);
        i_line_len   <= line_len_t'(len);
        i_num_lines  <= line_len_t'(lines);
        i_start      <= 1'b1;
        started      <= 1'b1;
        cur_len      = len;
        lines_seen   = 0;
        line_results = 0;
        @(posedge clk);
        i_start <= 1'b0;
        load_weights();
        for (int ln = 0; ln < lines; ln++) begin
            for (int col = 0; col < len; col++) begin
                send_pixel(col, len);
            end
        end
        @(posedge clk);
        i_data_vld <= 1'b0;
        win_done   <= 1'b0;
        line_end   <= 1'b0;
        do begin
            @(negedge clk);
        end while (!o_done);
        check_value("lines finished", lines_seen, lines);
        check_value("o_data_req", 32'(o_data_req), 32'd0);
        check_value("windows left in queue", exp_q.size(), 32'd0);
    endtask

    initial begin
        seed         = 32'heee5;
        rst          = 1'b1;
        i_start      = 1'b0;
        i_line_len   = '0;
        i_num_lines  = '0;
        i_weight     = '0;
        i_weight_vld = 1'b0;
        i_data       = '0;
        i_data_vld   = 1'b0;
        started      = 1'b0;
        win_done     = 1'b0;
        line_end     = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // Quiet period before the first start
        repeat (6) @(posedge clk);
        run_case(LEN_A, LINES_A);
        run_case(LEN_B, LINES_B);
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        repeat (200 + 4*TOTAL_PIX) @(posedge clk);
        stop_with("watchdog expired before both runs finished");
    end

endmodule

// File: build.f
+incdir+bench
source/conv_pkg.sv
source/line_window.sv
source/weight_store.sv
source/engine_ctrl.sv
source/kc_pe.sv
source/psum_collect.sv
source/line_conv_engine.sv
bench/line_conv_engine_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the line convolution engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module line_conv_engine_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vline_conv_engine_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi
exit 0
